// File: oflow_iou.f
src/oflow_iou_pkg.sv
src/oflow_bbox_decode.sv
src/oflow_iou_div.sv
src/oflow_calc_iou.sv
src/oflow_iou_result.sv
src/oflow_iou_top.sv
tb/oflow_iou_sva.sv
tb/oflow_iou_tb.sv

// File: Makefile
# Verilator build and run of the box iou testbench

VERILATOR ?= verilator
TOP       ?= oflow_iou_tb
FILELIST  ?= oflow_iou.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi
	@echo "simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/oflow_iou_tb.sv
// -------------------------------------------------------------------------
// testbench for the box iou subsystem
// directed and random box pairs, reference result queue,
// concurrent checks on every output transfer
// -------------------------------------------------------------------------
`timescale 1ns/1ps

module oflow_iou_tb;
	import oflow_iou_pkg::*;

	localparam int COORD_W        = COORD_W_DEF;
	localparam int FRAC_W         = FRAC_W_DEF;
	localparam int BOX_W          = 4*COORD_W;
	localparam int TIMEOUT_CYCLES = 20000;
	// sink behavior
	localparam int SINK_RANDOM    = 0;
	localparam int SINK_READY     = 1;
	localparam int SINK_STALL     = 2;

	logic                clk, reset_N;
	logic                in_valid, in_ready, out_valid, out_ready, degenerate;
	logic [BOX_W-1:0]    box_k, box_hist;
	logic [FRAC_W-1:0]   iou, iou_dist;

	// expected results in arrival order
	logic [FRAC_W-1:0]   exp_iou_q[$];
	logic [FRAC_W-1:0]   exp_dist_q[$];
	logic                exp_deg_q[$];
	logic [FRAC_W-1:0]   head_iou, head_dist;
	logic                head_valid = 1'b0;
	logic                head_deg;
	// transfers seen at the falling edge land on the next rising edge
	logic                in_fire = 1'b0;
	logic                out_fire = 1'b0;
	logic                saw_stall = 1'b0;
	logic [BOX_W-1:0]    fire_k, fire_hist;
	int                  cycles = 0;
	int                  ready_mode = SINK_READY;
	int                  sink_mode;

	oflow_iou_top oflow_iou_top_i (.*);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "run stopped at first error");
	endtask

	function automatic logic [BOX_W-1:0] make_box(input int x0, y0, x1, y1);
		logic [BOX_W-1:0] b;
		b = '0;
		b[X_TL_POS*COORD_W +: COORD_W] = COORD_W'(x0);
		b[Y_TL_POS*COORD_W +: COORD_W] = COORD_W'(y0);
		b[X_BR_POS*COORD_W +: COORD_W] = COORD_W'(x1);
		b[Y_BR_POS*COORD_W +: COORD_W] = COORD_W'(y1);
		return b;
	endfunction

	function automatic longint corner(input logic [BOX_W-1:0] b, input int pos);
		return longint'(b >> (pos*COORD_W)) & ((longint'(1) << COORD_W) - 1);
	endfunction

	function automatic longint pos_part(input longint v);
		return (v > 0) ? v : 0;
	endfunction

	// ---------------------------------------------------------------------------
	// reference model
	// ---------------------------------------------------------------------------

	// iou is floor(inter * 2^FRAC_W / union) clipped to all ones
	task automatic push_expected(input logic [BOX_W-1:0] bk, bh);
		longint kx0, ky0, kx1, ky1, hx0, hy0, hx1, hy1;
		longint iw, ih, ak, ah, uni, q, ones;
		kx0 = corner(bk, X_TL_POS);
		ky0 = corner(bk, Y_TL_POS);
		kx1 = corner(bk, X_BR_POS);
		ky1 = corner(bk, Y_BR_POS);
		hx0 = corner(bh, X_TL_POS);
		hy0 = corner(bh, Y_TL_POS);
		hx1 = corner(bh, X_BR_POS);
		hy1 = corner(bh, Y_BR_POS);
		ones = (longint'(1) << FRAC_W) - 1;
		ak = pos_part(kx1 - kx0) * pos_part(ky1 - ky0);
		ah = pos_part(hx1 - hx0) * pos_part(hy1 - hy0);
		// overlap from larger top-left and smaller bottom-right
		iw = pos_part(((kx1 < hx1) ? kx1 : hx1) - ((kx0 > hx0) ? kx0 : hx0));
		ih = pos_part(((ky1 < hy1) ? ky1 : hy1) - ((ky0 > hy0) ? ky0 : hy0));
		uni = ak + ah - iw*ih;
		if (uni == 0) begin
			exp_iou_q.push_back('0);
			exp_dist_q.push_back('1);
			exp_deg_q.push_back(1'b1);
		end else begin
			q = ((iw*ih) << FRAC_W) / uni;
			if (q > ones)
				q = ones;
			exp_iou_q.push_back(FRAC_W'(q));
			exp_dist_q.push_back(FRAC_W'(ones - q));
			exp_deg_q.push_back(1'b0);
		end
	endtask

	// handshakes are settled by the falling edge
	always @(negedge clk) begin
		if (in_fire)
			push_expected(fire_k, fire_hist);
		if (out_fire && exp_iou_q.size() > 0) begin
			void'(exp_iou_q.pop_front());
			void'(exp_dist_q.pop_front());
			void'(exp_deg_q.pop_front());
		end
		in_fire = reset_N && in_valid && in_ready;
		out_fire = reset_N && out_valid && out_ready;
		fire_k = box_k;
		fire_hist = box_hist;
		// source blocked while the sink holds off a finished result
		if (reset_N && in_valid && !in_ready && out_valid && !out_ready)
			saw_stall = 1'b1;
		head_valid = exp_iou_q.size() > 0;
		if (head_valid) begin
			head_iou = exp_iou_q[0];
			head_dist = exp_dist_q[0];
			head_deg = exp_deg_q[0];
		end
	end

	// ---------------------------------------------------------------------------
	// checking
	// ---------------------------------------------------------------------------

	a_reset_state: assert property (@(posedge clk) !reset_N |-> in_ready && !out_valid)
		else abort_run("in_ready low or out_valid high during reset");

	a_has_expected: assert property (@(posedge clk) disable iff (!reset_N)
			out_valid |-> head_valid)
		else abort_run("out_valid high with no accepted pair outstanding");

	a_iou: assert property (@(posedge clk) disable iff (!reset_N)
			out_valid && out_ready |-> iou == head_iou)
		else abort_run($sformatf("MISMATCH iou: got 0x%h expected 0x%h",
			$sampled(iou), $sampled(head_iou)));

	a_iou_dist: assert property (@(posedge clk) disable iff (!reset_N)
			out_valid && out_ready |-> iou_dist == head_dist)
		else abort_run($sformatf("MISMATCH iou_dist: got 0x%h expected 0x%h",
			$sampled(iou_dist), $sampled(head_dist)));

	a_degenerate: assert property (@(posedge clk) disable iff (!reset_N)
			out_valid && out_ready |-> degenerate == head_deg)
		else abort_run($sformatf("MISMATCH degenerate: got 0x%h expected 0x%h",
			$sampled(degenerate), $sampled(head_deg)));

	// ---------------------------------------------------------------------------
	// clock, timeout, sink
	// ---------------------------------------------------------------------------

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			abort_run($sformatf("timeout: run still busy after %0d cycles", cycles));
	end

	// mode read at the edge
	// ready driven just after
	always begin
		@(posedge clk);
		sink_mode = ready_mode;
		#1;
		case (sink_mode)
			SINK_RANDOM: out_ready = ($urandom_range(3) != 0);
			SINK_READY:  out_ready = 1'b1;
			default:     out_ready = 1'b0;
		endcase
	end

	// ---------------------------------------------------------------------------
	// stimulus entered and left 1 ns after a rising edge
	// ---------------------------------------------------------------------------

	task automatic send_pair(input logic [BOX_W-1:0] bk, bh, input int gap);
		logic took;
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
		in_valid = 1'b1;
		box_k = bk;
		box_hist = bh;
		do begin
			@(negedge clk);
			took = in_ready;
			@(posedge clk);
		end while (!took);
		#1;
		in_valid = 1'b0;
	endtask

	// mostly overlapping pairs with some identical, inverted or unrelated
	task automatic send_random(input int gap);
		int x0, y0, w, h, hx, hy;
		logic [BOX_W-1:0] bk, bh;
		x0 = $urandom_range(767);
		y0 = $urandom_range(767);
		w = $urandom_range(255);
		h = $urandom_range(255);
		hx = x0 + int'($urandom_range(127)) - 64;
		hy = y0 + int'($urandom_range(127)) - 64;
		hx = (hx < 0) ? 0 : ((hx > 767) ? 767 : hx);
		hy = (hy < 0) ? 0 : ((hy > 767) ? 767 : hy);
		bk = make_box(x0, y0, x0 + w, y0 + h);
		bh = make_box(hx, hy, hx + int'($urandom_range(255)), hy + int'($urandom_range(255)));
		case ($urandom_range(7))
			0: bh = bk;
			1: bk = make_box(x0 + w, y0 + h, x0, y0);
			2: bh = make_box($urandom_range(1023), $urandom_range(1023),
				$urandom_range(1023), $urandom_range(1023));
			default: ;
		endcase
		send_pair(bk, bh, gap);
	endtask

	initial begin
		void'($urandom(32'hd2d875bd));
		reset_N = 1'b0;
		in_valid = 1'b0;
		box_k = '0;
		box_hist = '0;
		out_ready = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		reset_N = 1'b1;
		// identical, full frame, disjoint, edge touch, two zero-area, inverted, contained
		send_pair(make_box(100, 100, 200, 180), make_box(100, 100, 200, 180), 0);
		send_pair(make_box(0, 0, 1023, 1023), make_box(0, 0, 1023, 1023), 1);
		send_pair(make_box(10, 10, 50, 50), make_box(300, 300, 400, 400), 0);
		send_pair(make_box(10, 10, 50, 50), make_box(50, 10, 90, 50), 0);
		send_pair(make_box(20, 20, 20, 60), make_box(70, 70, 90, 70), 2);
		send_pair(make_box(200, 200, 100, 100), make_box(100, 100, 200, 200), 0);
		send_pair(make_box(0, 0, 1023, 1023), make_box(100, 100, 101, 101), 0);
		// random sink
		ready_mode = SINK_RANDOM;
		repeat (250) send_random(int'($urandom_range(3)));
		// long stall fills every stage and blocks the source
		ready_mode = SINK_STALL;
		fork
			repeat (6) send_random(0);
			begin
				repeat (120) @(posedge clk);
				#1;
				ready_mode = SINK_READY;
			end
		join
		repeat (20) send_random(int'($urandom_range(3)));
		// drain until every expected result is taken
		// a lost pair runs into the timeout
		while (head_valid || out_valid) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		if (saw_stall) begin
			$display("Done: no errors");
			$finish;
		end else begin
			abort_run("in_ready never fell while the sink stalled");
		end
	end

endmodule

// File: tb/oflow_iou_sva.sv
// -------------------------------------------------------------------------
// handshake assertions for the box iou subsystem
// output hold under back-pressure and transfer accounting
// -------------------------------------------------------------------------
`timescale 1ns/1ps

module oflow_iou_sva #(
	parameter int FRAC_W = 16
) (
	input logic                clk,
	input logic                reset_N,
	input logic                in_valid,
	input logic                in_ready,
	input logic                out_valid,
	input logic                out_ready,
	input logic [FRAC_W-1:0]   iou,
	input logic [FRAC_W-1:0]   iou_dist,
	input logic                degenerate
);

	// pairs accepted and not yet delivered
	logic [2:0] inflight;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			inflight <= '0;
		end else begin
			inflight <= inflight + 3'(in_valid && in_ready) - 3'(out_valid && out_ready);
		end
	end

	// stalled result stays offered
	a_out_hold: assert property (@(posedge clk) disable iff (!reset_N)
			out_valid && !out_ready |=> out_valid)
		else $error("out_valid dropped before the sink took the result");

	// and unchanged
	a_out_stable: assert property (@(posedge clk) disable iff (!reset_N)
			out_valid && !out_ready |=> $stable(iou) && $stable(iou_dist) && $stable(degenerate))
		else $error("result outputs changed while stalled");

	// no result without an accepted pair behind it
	a_out_cause: assert property (@(posedge clk) disable iff (!reset_N)
			out_valid |-> inflight != 3'd0)
		else $error("out_valid high with no pair in flight");

	// decode, execute and result register hold one pair each
	a_depth: assert property (@(posedge clk) disable iff (!reset_N)
			inflight <= 3'd3)
		else $error("more than three pairs in flight");

endmodule

bind oflow_iou_top oflow_iou_sva #(
	.FRAC_W (FRAC_W)
) oflow_iou_sva_i (
	.clk        (clk),
	.reset_N    (reset_N),
	.in_valid   (in_valid),
	.in_ready   (in_ready),
	.out_valid  (out_valid),
	.out_ready  (out_ready),
	.iou        (iou),
	.iou_dist   (iou_dist),
	.degenerate (degenerate)
);

// File: src/oflow_iou_top.sv
// -------------------------------------------------------------------------
// optical-flow box iou subsystem
// decode, execute and result stages joined by valid/ready handshakes
// -------------------------------------------------------------------------
`timescale 1ns/1ps

module oflow_iou_top #(
	parameter int COORD_W = oflow_iou_pkg::COORD_W_DEF,
	parameter int FRAC_W  = oflow_iou_pkg::FRAC_W_DEF
) (
	input  logic                   clk,
	input  logic                   reset_N,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  logic [4*COORD_W-1:0]   box_k,
	input  logic [4*COORD_W-1:0]   box_hist,
	output logic                   out_valid,
	input  logic                   out_ready,
	output logic [FRAC_W-1:0]      iou,
	output logic [FRAC_W-1:0]      iou_dist,
	output logic                   degenerate
);

	localparam int A_W = 2*COORD_W + FRAC_W;

	// decode to execute
	logic                 dec_valid, dec_ready;
	logic [2*COORD_W-1:0] area_k, area_hist;
	logic [COORD_W-1:0]   ov_w, ov_h;
	// execute to result
	logic                 ex_valid, ex_ready;
	logic [A_W-1:0]       quotient;
	logic                 zero_union;

	oflow_bbox_decode #(
		.COORD_W (COORD_W)
	) oflow_bbox_decode_i (
		.clk       (clk),
		.reset_N   (reset_N),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.box_k     (box_k),
		.box_hist  (box_hist),
		.dec_valid (dec_valid),
		.dec_ready (dec_ready),
		.area_k    (area_k),
		.area_hist (area_hist),
		.ov_w      (ov_w),
		.ov_h      (ov_h)
	);

	oflow_calc_iou #(
		.COORD_W (COORD_W),
		.FRAC_W  (FRAC_W)
	) oflow_calc_iou_i (
		.clk        (clk),
		.reset_N    (reset_N),
		.dec_valid  (dec_valid),
		.dec_ready  (dec_ready),
		.area_k     (area_k),
		.area_hist  (area_hist),
		.ov_w       (ov_w),
		.ov_h       (ov_h),
		.ex_valid   (ex_valid),
		.ex_ready   (ex_ready),
		.quotient   (quotient),
		.zero_union (zero_union)
	);

	oflow_iou_result #(
		.COORD_W (COORD_W),
		.FRAC_W  (FRAC_W)
	) oflow_iou_result_i (
		.clk        (clk),
		.reset_N    (reset_N),
		.ex_valid   (ex_valid),
		.ex_ready   (ex_ready),
		.quotient   (quotient),
		.zero_union (zero_union),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.iou        (iou),
		.iou_dist   (iou_dist),
		.degenerate (degenerate)
	);

endmodule

// File: src/oflow_iou_result.sv
// -------------------------------------------------------------------------
// iou result stage
// saturates the raw quotient, forms match distance and degenerate flag,
// registered output that holds under back-pressure
// -------------------------------------------------------------------------
`timescale 1ns/1ps

module oflow_iou_result #(
	parameter int COORD_W = 10,
	parameter int FRAC_W  = 16
) (
	input  logic                          clk,
	input  logic                          reset_N,
	input  logic                          ex_valid,
	output logic                          ex_ready,
	input  logic [2*COORD_W+FRAC_W-1:0]   quotient,
	input  logic                          zero_union,
	output logic                          out_valid,
	input  logic                          out_ready,
	output logic [FRAC_W-1:0]             iou,
	output logic [FRAC_W-1:0]             iou_dist,
	output logic                          degenerate
);

	localparam int A_W = 2*COORD_W + FRAC_W;

	logic [FRAC_W-1:0] sat;

	// ratio of one or more clips to all ones
	assign sat = (|quotient[A_W-1:FRAC_W]) ? '1 : quotient[FRAC_W-1:0];

	// take a result when empty or draining
	assign ex_ready = !out_valid || out_ready;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			out_valid <= 1'b0;
		end else if (ex_ready) begin
			out_valid <= ex_valid;
		end
	end

	// outputs only move on accept, so they hold while stalled
	always_ff @(posedge clk) begin
		if (ex_valid && ex_ready) begin
			if (zero_union) begin
				iou        <= '0;
				iou_dist   <= '1;
				degenerate <= 1'b1;
			end else begin
				iou        <= sat;
				// all ones minus iou
				iou_dist   <= ~sat;
				degenerate <= 1'b0;
			end
		end
	end

endmodule

// File: src/oflow_calc_iou.sv
// -------------------------------------------------------------------------
// iou execute stage
// intersection and union areas, divider control, raw quotient hold
// quotient is intersection * 2^FRAC_W / union, unsaturated
// -------------------------------------------------------------------------
`timescale 1ns/1ps

module oflow_calc_iou #(
	parameter int COORD_W = 10,
	parameter int FRAC_W  = 16
) (
	input  logic                          clk,
	input  logic                          reset_N,
	input  logic                          dec_valid,
	output logic                          dec_ready,
	input  logic [2*COORD_W-1:0]          area_k,
	input  logic [2*COORD_W-1:0]          area_hist,
	input  logic [COORD_W-1:0]            ov_w,
	input  logic [COORD_W-1:0]            ov_h,
	output logic                          ex_valid,
	input  logic                          ex_ready,
	output logic [2*COORD_W+FRAC_W-1:0]   quotient,
	output logic                          zero_union
);
	import oflow_iou_pkg::*;

	localparam int A_W = 2*COORD_W + FRAC_W;
	localparam int B_W = 2*COORD_W + 1;

	calc_state_t          state;
	// captured at accept
	logic [B_W-1:0]       sum_r;
	logic [COORD_W-1:0]   ovw_r, ovh_r;
	// registered in area state
	logic [2*COORD_W-1:0] inter_r;
	logic [B_W-1:0]       union_r;
	logic                 union_zero;
	logic                 div_start, div_busy, div_done;
	logic [A_W-1:0]       dividend;
	logic [A_W-1:0]       div_q;

	assign dec_ready  = (state == CALC_IDLE);
	assign ex_valid   = (state == CALC_HOLD);
	assign union_zero = (union_r == '0);
	// intersection in fixed point
	assign dividend   = {inter_r, {FRAC_W{1'b0}}};
	// single pulse, busy and done cover the rest of divide
	assign div_start  = (state == CALC_DIVIDE) && !union_zero && !div_busy && !div_done;

	oflow_iou_div #(
		.A_W (A_W),
		.B_W (B_W)
	) oflow_iou_div_i (
		.clk       (clk),
		.reset_N   (reset_N),
		.div_start (div_start),
		.dividend  (dividend),
		.divisor   (union_r),
		.div_busy  (div_busy),
		.div_done  (div_done),
		.quotient  (div_q)
	);

	// state register and transitions
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= CALC_IDLE;
		end else begin
			case (state)
				CALC_IDLE:   if (dec_valid) state <= CALC_AREA;
				CALC_AREA:   state <= CALC_DIVIDE;
				CALC_DIVIDE: if (union_zero || div_done) state <= CALC_HOLD;
				CALC_HOLD:   if (ex_ready) state <= CALC_IDLE;
				default:     state <= CALC_IDLE;
			endcase
		end
	end

	// payload per state
	always_ff @(posedge clk) begin
		if (state == CALC_IDLE && dec_valid) begin
			sum_r <= B_W'(area_k) + B_W'(area_hist);
			ovw_r <= ov_w;
			ovh_r <= ov_h;
		end
		if (state == CALC_AREA) begin
			inter_r <= (2*COORD_W)'(ovw_r) * (2*COORD_W)'(ovh_r);
			// overlap never exceeds either box, no underflow
			union_r <= sum_r - B_W'((2*COORD_W)'(ovw_r) * (2*COORD_W)'(ovh_r));
		end
		if (state == CALC_DIVIDE) begin
			if (union_zero) begin
				quotient   <= '0;
				zero_union <= 1'b1;
			end else if (div_done) begin
				quotient   <= div_q;
				zero_union <= 1'b0;
			end
		end
	end

endmodule

// File: src/oflow_iou_div.sv
// -------------------------------------------------------------------------
// sequential restoring divider
// unsigned A_W / B_W, one quotient bit per cycle, MSB first
// done pulses A_W cycles after start, quotient held until next start
// -------------------------------------------------------------------------
`timescale 1ns/1ps

module oflow_iou_div #(
	parameter int A_W = 36,
	parameter int B_W = 21
) (
	input  logic             clk,
	input  logic             reset_N,
	input  logic             div_start,
	input  logic [A_W-1:0]   dividend,
	input  logic [B_W-1:0]   divisor,
	output logic             div_busy,
	output logic             div_done,
	output logic [A_W-1:0]   quotient
);

	localparam int CNT_W = $clog2(A_W + 1);

	// dividend leaves at the top, quotient bits enter at the bottom
	logic [A_W-1:0]     work;
	// partial remainder, always below the divisor
	logic [B_W-1:0]     rem;
	logic [B_W-1:0]     dsor;
	// iterations still to run
	logic [CNT_W-1:0]   cnt;
	logic [B_W:0]       trial;
	logic [B_W:0]       diff;
	logic               q_bit;

	// -------------------------------------------------------------------------
	// one restoring step
	// -------------------------------------------------------------------------

	// bring down next dividend bit
	assign trial = {rem, work[A_W-1]};
	assign q_bit = (trial >= {1'b0, dsor});
	assign diff  = trial - {1'b0, dsor};

	// final quotient sits in the work register once done
	assign quotient = work;

	// -------------------------------------------------------------------------
	// control
	// -------------------------------------------------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			div_busy <= 1'b0;
			div_done <= 1'b0;
			cnt      <= '0;
		end else begin
			div_done <= 1'b0;
			if (div_start) begin
				div_busy <= 1'b1;
				cnt      <= CNT_W'(A_W);
			end else if (div_busy) begin
				cnt <= cnt - 1'b1;
				// last step lands this edge
				if (cnt == CNT_W'(1)) begin
					div_busy <= 1'b0;
					div_done <= 1'b1;
				end
			end
		end
	end

	// -------------------------------------------------------------------------
	// datapath
	// -------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (div_start) begin
			work <= dividend;
			rem  <= '0;
			dsor <= divisor;
		end else if (div_busy) begin
			work <= {work[A_W-2:0], q_bit};
			// restore by keeping the unsubtracted value
			rem  <= q_bit ? diff[B_W-1:0] : trial[B_W-1:0];
		end
	end

endmodule

// File: src/oflow_bbox_decode.sv
// -------------------------------------------------------------------------
// box pair decode stage
// splits both box words into corners, clamps inverted boxes to zero size,
// forms both areas and the overlap extent, one-entry registered stage
// -------------------------------------------------------------------------
`timescale 1ns/1ps

module oflow_bbox_decode #(
	parameter int COORD_W = 10
) (
	input  logic                   clk,
	input  logic                   reset_N,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  logic [4*COORD_W-1:0]   box_k,
	input  logic [4*COORD_W-1:0]   box_hist,
	output logic                   dec_valid,
	input  logic                   dec_ready,
	output logic [2*COORD_W-1:0]   area_k,
	output logic [2*COORD_W-1:0]   area_hist,
	output logic [COORD_W-1:0]     ov_w,
	output logic [COORD_W-1:0]     ov_h
);
	import oflow_iou_pkg::*;

	// one corner out of a box word
	function automatic logic [COORD_W-1:0] field(input logic [4*COORD_W-1:0] box,
			input int pos);
		return box[pos*COORD_W +: COORD_W];
	endfunction

	// extent along one axis, zero unless br is past tl
	function automatic logic [COORD_W-1:0] span(input logic [COORD_W-1:0] tl,
			input logic [COORD_W-1:0] br);
		return (br > tl) ? br - tl : '0;
	endfunction

	// clamped box sizes
	logic [COORD_W-1:0]   k_w, k_h;
	logic [COORD_W-1:0]   h_w, h_h;
	// overlap corners
	logic [COORD_W-1:0]   o_x_tl, o_y_tl, o_x_br, o_y_br;
	logic                 accept;

	assign k_w = span(field(box_k, X_TL_POS), field(box_k, X_BR_POS));
	assign k_h = span(field(box_k, Y_TL_POS), field(box_k, Y_BR_POS));
	assign h_w = span(field(box_hist, X_TL_POS), field(box_hist, X_BR_POS));
	assign h_h = span(field(box_hist, Y_TL_POS), field(box_hist, Y_BR_POS));

	// overlap is larger top-left and smaller bottom-right
	// an inverted box always yields an empty overlap here
	assign o_x_tl = (field(box_k, X_TL_POS) > field(box_hist, X_TL_POS)) ?
			field(box_k, X_TL_POS) : field(box_hist, X_TL_POS);
	assign o_y_tl = (field(box_k, Y_TL_POS) > field(box_hist, Y_TL_POS)) ?
			field(box_k, Y_TL_POS) : field(box_hist, Y_TL_POS);
	assign o_x_br = (field(box_k, X_BR_POS) < field(box_hist, X_BR_POS)) ?
			field(box_k, X_BR_POS) : field(box_hist, X_BR_POS);
	assign o_y_br = (field(box_k, Y_BR_POS) < field(box_hist, Y_BR_POS)) ?
			field(box_k, Y_BR_POS) : field(box_hist, Y_BR_POS);

	// take a pair when empty or draining this cycle
	assign in_ready = !dec_valid || dec_ready;
	assign accept = in_valid && in_ready;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			dec_valid <= 1'b0;
		end else if (in_ready) begin
			dec_valid <= in_valid;
		end
	end

	// payload, full-width products
	always_ff @(posedge clk) begin
		if (accept) begin
			area_k    <= (2*COORD_W)'(k_w) * (2*COORD_W)'(k_h);
			area_hist <= (2*COORD_W)'(h_w) * (2*COORD_W)'(h_h);
			ov_w      <= span(o_x_tl, o_x_br);
			ov_h      <= span(o_y_tl, o_y_br);
		end
	end

endmodule

// File: src/oflow_iou_pkg.sv
// -------------------------------------------------------------------------
// optical-flow iou package
// default geometry widths, box corner field order, execute FSM states
// -------------------------------------------------------------------------
package oflow_iou_pkg;

	// -------------------------------------------------------------------------
	// default widths
	// -------------------------------------------------------------------------

	// unsigned pixel coordinate
	localparam int COORD_W_DEF = 10;

	// fraction bits of the iou ratio
	localparam int FRAC_W_DEF = 16;

	// -------------------------------------------------------------------------
	// box word layout
	// -------------------------------------------------------------------------

	// field index of each corner, top field first
	// box word is {x_tl, y_tl, x_br, y_br}, bottom-right exclusive
	localparam int X_TL_POS = 3;
	localparam int Y_TL_POS = 2;
	localparam int X_BR_POS = 1;
	localparam int Y_BR_POS = 0;

	// -------------------------------------------------------------------------
	// execute stage FSM
	// -------------------------------------------------------------------------

	// idle    waits for a decoded pair
	// area    registers intersection and union
	// divide  runs the divider, or skips it on zero union
	// hold    offers the raw quotient to the result stage
	typedef enum logic [1:0] {
		CALC_IDLE   = 2'd0,
		CALC_AREA   = 2'd1,
		CALC_DIVIDE = 2'd2,
		CALC_HOLD   = 2'd3
	} calc_state_t;

endpackage
